// ==== dv/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam word_t RESET_PC  = 32'h0000_0100;
    localparam int    MEM_WORDS = 1024;          // 4 KB indexed by byte address bits [11:2]
    localparam word_t SEED      = 32'h9fa0526c;

    logic     clk = 1'b0;
    logic     rst;
    bus_req_t bus_o;
    word_t    bus_rdata_i;
    logic     bus_full_i = 1'b0;

    word_t    img [0:MEM_WORDS-1];   // image loaded into the memory during reset
    word_t    mem [0:MEM_WORDS-1];
    word_t    emit_adr;
    bus_req_t exp_q [$];             // expected stores in program order
    int       store_idx;
    logic     first_read_seen;
    int       bus_errs  = 0;
    int       main_errs = 0;
    int       cyc       = 0;
    int       deadline  = 1000;
    logic     stall_en  = 1'b0;
    word_t    rng       = SEED;

    cpu_core #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .bus_o(bus_o),
        .bus_rdata_i(bus_rdata_i),
        .bus_full_i(bus_full_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // memory model answers in the transfer cycle
    assign bus_rdata_i = bus_o.read ? mem[bus_o.adr[11:2]] : 32'h0;

    always @(posedge clk) begin
        if (rst) begin
            mem <= img;
        end else if (bus_o.write) begin
            mem[bus_o.adr[11:2]] <= bus_o.wdata;
        end
    end

    function automatic word_t xorshift32(input word_t s);
        word_t v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // back-pressure on about three cycles in four when enabled
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            rng = xorshift32(rng);
            bus_full_i = (rng[1:0] != 2'b00);
        end else begin
            bus_full_i = 1'b0;
        end
    end

    function automatic word_t r_type(input int f7, input int rs2, input int rs1, input int f3,
                                     input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPCODE_OP};
    endfunction

    function automatic word_t i_type(input int imm, input int rs1, input int f3, input int rd,
                                     input opcode_t op);
        word_t v;
        v = imm;
        return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t s_type(input int imm, input int rs2, input int rs1);
        word_t v;
        v = imm;
        return {v[11:5], rs2[4:0], rs1[4:0], 3'b010, v[4:0], OPCODE_STORE};
    endfunction

    function automatic word_t b_type(input int imm, input int rs1, input int rs2, input int f3);
        word_t v;
        v = imm;
        return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], OPCODE_BRANCH};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        word_t v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd[4:0], OPCODE_JAL};
    endfunction

    function automatic word_t u_type(input int up, input int rd);
        return {up[19:0], rd[4:0], OPCODE_LUI};
    endfunction

    task automatic put_word(input word_t w);
        img[emit_adr[11:2]] = w;
        emit_adr = emit_adr + 32'd4;
    endtask

    task automatic fill_memory();
        word_t a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = word_t'(i) << 2;
            img[i] = a ^ {a[15:0], ~a[15:0]};
        end
    endtask

    task automatic alu_program();
        put_word(i_type(12'h123, 0, 0, 1, OPCODE_OP_IMM));
        put_word(i_type(-5, 0, 0, 2, OPCODE_OP_IMM));
        put_word(u_type(20'habcde, 3));
        put_word(i_type(12'h600, 0, 0, 11, OPCODE_OP_IMM)); // store base
        put_word(r_type(0, 2, 1, 0, 4));     // add
        put_word(s_type(0, 4, 11));
        put_word(r_type(7'h20, 2, 1, 0, 5)); // sub
        put_word(s_type(4, 5, 11));
        put_word(r_type(0, 1, 3, 4, 6));     // xor
        put_word(s_type(8, 6, 11));
        put_word(r_type(0, 2, 3, 6, 7));     // or
        put_word(s_type(12, 7, 11));
        put_word(r_type(0, 2, 3, 7, 8));     // and
        put_word(s_type(16, 8, 11));
        put_word(i_type(7, 0, 0, 9, OPCODE_OP_IMM));
        put_word(r_type(0, 9, 1, 1, 12));    // sll
        put_word(s_type(20, 12, 11));
        put_word(r_type(0, 9, 2, 5, 13));    // srl
        put_word(s_type(24, 13, 11));
        put_word(i_type(12'h7ff, 1, 4, 14, OPCODE_OP_IMM));
        put_word(s_type(28, 14, 11));
        put_word(i_type(-256, 1, 6, 15, OPCODE_OP_IMM));
        put_word(s_type(32, 15, 11));
        put_word(i_type(12'h0f0, 2, 7, 16, OPCODE_OP_IMM));
        put_word(s_type(36, 16, 11));
        put_word(i_type(20, 1, 1, 17, OPCODE_OP_IMM));
        put_word(s_type(40, 17, 11));
        put_word(i_type(4, 2, 5, 18, OPCODE_OP_IMM));
        put_word(s_type(44, 18, 11));
        put_word(r_type(0, 2, 1, 2, 19));    // funct3 010 adds as well
        put_word(s_type(48, 19, 11));
        put_word(s_type(52, 3, 11));         // lui value
        put_word(j_type(0, 0));
    endtask

    task automatic load_program();
        img[256] = 32'h1234_5678;            // data region at 0x400
        img[257] = 32'h0f0f_0f0f;
        img[258] = 32'h8000_0001;
        put_word(i_type(12'h400, 0, 0, 10, OPCODE_OP_IMM));
        put_word(i_type(12'h600, 0, 0, 11, OPCODE_OP_IMM));
        put_word(i_type(0, 10, 2, 1, OPCODE_LOAD));
        put_word(i_type(4, 10, 2, 2, OPCODE_LOAD));
        put_word(i_type(8, 10, 2, 3, OPCODE_LOAD));
        put_word(r_type(0, 2, 1, 0, 4));
        put_word(s_type(0, 4, 11));
        put_word(r_type(7'h20, 1, 3, 0, 5));
        put_word(s_type(4, 5, 11));
        put_word(i_type(-4, 11, 2, 6, OPCODE_LOAD)); // negative offset into fill data
        put_word(s_type(8, 6, 11));
        put_word(i_type(0, 11, 2, 7, OPCODE_LOAD));  // reads back the first store
        put_word(i_type(1, 7, 0, 7, OPCODE_OP_IMM));
        put_word(s_type(12, 7, 11));
        put_word(j_type(0, 0));
    endtask

    // taken skips the marker store and both paths reach the join store
    task automatic branch_case(input int idx, input int f3, input int rs1, input int rs2);
        put_word(b_type(8, rs1, rs2, f3));
        put_word(s_type(idx * 8, 1, 11));
        put_word(s_type(idx * 8 + 4, 3, 11));
    endtask

    task automatic branch_program();
        put_word(i_type(12'h600, 0, 0, 11, OPCODE_OP_IMM));
        put_word(i_type(5, 0, 0, 1, OPCODE_OP_IMM));
        put_word(i_type(5, 0, 0, 2, OPCODE_OP_IMM));
        put_word(i_type(-1, 0, 0, 3, OPCODE_OP_IMM));
        branch_case(0, 0, 1, 2);
        branch_case(1, 0, 1, 3);
        branch_case(2, 1, 1, 3);
        branch_case(3, 1, 1, 2);
        branch_case(4, 4, 1, 3);
        branch_case(5, 4, 3, 1);
        branch_case(6, 5, 3, 1);
        branch_case(7, 5, 1, 3);
        put_word(i_type(3, 0, 0, 4, OPCODE_OP_IMM));   // countdown loop
        put_word(i_type(-1, 4, 0, 4, OPCODE_OP_IMM));
        put_word(s_type(64, 4, 11));
        put_word(b_type(-8, 4, 0, 1));                 // backward bne
        put_word(j_type(0, 0));
    endtask

    task automatic jal_program();
        put_word(i_type(12'h600, 0, 0, 11, OPCODE_OP_IMM));
        put_word(j_type(12, 1));
        put_word(s_type(0, 0, 11));          // skipped
        put_word(s_type(4, 0, 11));          // skipped
        put_word(s_type(8, 1, 11));          // link of the first jal
        put_word(j_type(8, 5));
        put_word(i_type(99, 0, 0, 6, OPCODE_OP_IMM));
        put_word(s_type(12, 5, 11));
        put_word(s_type(16, 6, 11));
        put_word(j_type(12, 7));
        put_word(s_type(20, 7, 11));
        put_word(j_type(0, 0));
        put_word(j_type(-8, 0));             // jumps back to the store of x7
    endtask

    task automatic build_program(input int t);
        fill_memory();
        emit_adr = RESET_PC;
        case (t)
            0: alu_program();
            1: load_program();
            2: branch_program();
            default: jal_program();
        endcase
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input word_t a, input word_t b,
                                      input logic sub);
        word_t r;
        case (f3)
            3'b000, 3'b010: r = sub ? a - b : a + b;
            3'b100: r = a ^ b;
            3'b110: r = a | b;
            3'b111: r = a & b;
            3'b001: r = a << b[4:0];
            3'b101: r = a >> b[4:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    // instruction-set model that collects the stores into exp_q
    function automatic int run_reference();
        word_t    rm [0:MEM_WORDS-1];
        word_t    x [0:31];
        word_t    pc, ins, imm, a, b, r, adr, next;
        bus_req_t st;
        logic     wr, done, take;
        int       steps;
        rm = img;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = RESET_PC;
        done = 1'b0;
        steps = 0;
        exp_q.delete();
        while (!done && steps < 4000) begin
            ins = rm[pc[11:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            wr = 1'b0;
            r = '0;
            next = pc + 32'd4;
            case (ins[6:0])
                OPCODE_OP: begin
                    wr = 1'b1;
                    r = alu_ref(ins[14:12], a, b, ins[31:25] == 7'h20);
                end
                OPCODE_OP_IMM: begin
                    wr = 1'b1;
                    r = alu_ref(ins[14:12], a, {{20{ins[31]}}, ins[31:20]}, 1'b0);
                end
                OPCODE_LOAD: begin
                    adr = a + {{20{ins[31]}}, ins[31:20]};
                    wr = 1'b1;
                    r = rm[adr[11:2]];
                end
                OPCODE_STORE: begin
                    adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    rm[adr[11:2]] = b;
                    st = '0;
                    st.write = 1'b1;
                    st.adr = adr;
                    st.wdata = b;
                    exp_q.push_back(st);
                end
                OPCODE_BRANCH: begin
                    imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    case (ins[14:12])
                        3'b000: take = (a == b);
                        3'b001: take = (a != b);
                        3'b100: take = (a < b);   // unsigned
                        3'b101: take = (a >= b);
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        next = pc + imm;
                    end
                end
                OPCODE_JAL: begin
                    imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    wr = 1'b1;
                    r = pc + 32'd4;
                    next = pc + imm;
                    done = (imm == 32'h0); // jump to self ends the program
                end
                OPCODE_LUI: begin
                    wr = 1'b1;
                    r = {ins[31:12], 12'h000};
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = r;
            end
            pc = next;
            steps++;
        end
        return exp_q.size();
    endfunction

    task automatic check_store(input int idx, input bus_req_t exp, input bus_req_t got);
        if (got.read !== exp.read) begin
            $display("FAIL bus_o.read store %0d exp %h got %h", idx, exp.read, got.read);
            bus_errs++;
        end
        if (got.adr !== exp.adr) begin
            $display("FAIL bus_o.adr store %0d exp %h got %h", idx, exp.adr, got.adr);
            bus_errs++;
        end
        if (got.wdata !== exp.wdata) begin
            $display("FAIL bus_o.wdata store %0d exp %h got %h", idx, exp.wdata, got.wdata);
            bus_errs++;
        end
    endtask

    task automatic check_adr(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("FAIL %s exp %h got %h", name, exp, got);
            bus_errs++;
        end
    endtask

    task automatic check_idle(input bus_req_t got);
        if (got.read !== 1'b0) begin
            $display("FAIL bus_o.read exp 0 got %h", got.read);
            main_errs++;
        end
        if (got.write !== 1'b0) begin
            $display("FAIL bus_o.write exp 0 got %h", got.write);
            main_errs++;
        end
    endtask

    // bus monitor compares each write with the model in order
    always @(posedge clk) begin
        if (rst) begin
            store_idx = 0;
            first_read_seen = 1'b0;
        end else begin
            if (bus_o.read && bus_o.write) begin
                $display("read and write driven together on the bus at cycle %0d", cyc);
                bus_errs++;
            end
            if (bus_o.read && !first_read_seen) begin
                check_adr("bus_o.adr", RESET_PC, bus_o.adr); // first fetch
                first_read_seen = 1'b1;
            end
            if (bus_o.write) begin
                if (store_idx < exp_q.size()) begin
                    check_store(store_idx, exp_q[store_idx], bus_o);
                end else begin
                    $display("unexpected extra store to address %h", bus_o.adr);
                    bus_errs++;
                end
                store_idx++;
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_idle(bus_o);
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle(bus_o); // arbiter has only seen the first request
    endtask

    task automatic run_test(input int t, input int stalled);
        int n;
        build_program(t);
        n = run_reference();
        stall_en = (stalled != 0);
        deadline = cyc + n * 400 + 500;
        $display("program %0d, stall mode %0d, %0d stores expected", t, stalled, n);
        apply_reset();
        while (store_idx < n) begin
            @(posedge clk);
            #1;
        end
        repeat (40) @(posedge clk); // catch stray stores after the end loop
        #1;
        if (!first_read_seen) begin
            $display("no instruction fetch seen after reset in program %0d", t);
            main_errs++;
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < 4; t++) begin
                run_test(t, pass);
            end
        end
        $display("bus errors %0d, other errors %0d", bus_errs, main_errs);
        if (bus_errs + main_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog deadline moves forward with each program
    initial begin
        while (cyc <= deadline) begin
            @(posedge clk);
        end
        $display("timeout at cycle %0d, store %0d of %0d seen", cyc, store_idx, exp_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cpu_core_tb -f tb.f -o cpu_core_sim
out=$(./obj_dir/cpu_core_sim)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  decoded_t dec_i,
    input  word_t    pc_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    output word_t    result_o,
    output word_t    mem_adr_o,
    output logic     branch_taken_o
);

    word_t op_b;
    word_t alu_out;

    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

    always_comb begin
        case (dec_i.funct3)
            3'b000, 3'b010: alu_out = dec_i.sub ? (rs1_data_i - op_b) : (rs1_data_i + op_b);
            3'b100:         alu_out = rs1_data_i ^ op_b;
            3'b110:         alu_out = rs1_data_i | op_b;
            3'b111:         alu_out = rs1_data_i & op_b;
            3'b001:         alu_out = rs1_data_i << op_b[4:0];
            3'b101:         alu_out = rs1_data_i >> op_b[4:0]; // logical only
            default:        alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec_i.op_class)
            OPC_ALU: result_o = alu_out;
            OPC_LUI: result_o = dec_i.imm;
            OPC_JAL: result_o = pc_i + 32'd4; // link value
            default: result_o = '0;
        endcase
    end

    assign mem_adr_o = rs1_data_i + dec_i.imm;

    // compares are unsigned
    always_comb begin
        branch_taken_o = 1'b0;
        if (dec_i.op_class == OPC_JAL) begin
            branch_taken_o = 1'b1;
        end else if (dec_i.op_class == OPC_BRANCH) begin
            case (dec_i.funct3)
                3'b000:  branch_taken_o = (rs1_data_i == rs2_data_i);
                3'b001:  branch_taken_o = (rs1_data_i != rs2_data_i);
                3'b100:  branch_taken_o = (rs1_data_i < rs2_data_i);
                3'b101:  branch_taken_o = (rs1_data_i >= rs2_data_i);
                default: branch_taken_o = 1'b0;
            endcase
        end
    end

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t fetch_req_i,
    input  bus_req_t lsu_req_i,
    input  logic     bus_full_i,
    input  word_t    bus_rdata_i,
    output bus_req_t bus_o,
    output logic     fetch_done_o,
    output logic     lsu_done_o,
    output word_t    rdata_o
);

    arb_state_t state, next_state;
    logic       owner_lsu;  // 1 when data side holds the grant
    bus_req_t   gnt_req;    // latched request of the owner
    logic       fetch_pend, lsu_pend;
    logic       xfer;

    assign fetch_pend = fetch_req_i.read || fetch_req_i.write;
    assign lsu_pend   = lsu_req_i.read || lsu_req_i.write;
    assign xfer       = (state == ARB_TRANSFER);

    always_comb begin
        next_state = state;
        case (state)
            ARB_IDLE: begin
                if (fetch_pend || lsu_pend) begin
                    next_state = ARB_REQUEST;
                end
            end
            ARB_REQUEST: next_state = bus_full_i ? ARB_WAIT : ARB_TRANSFER;
            ARB_WAIT:    next_state = bus_full_i ? ARB_WAIT : ARB_TRANSFER;
            ARB_TRANSFER: next_state = ARB_IDLE; // bus_full ignored here
            default:     next_state = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ARB_IDLE;
            owner_lsu <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ARB_IDLE && (fetch_pend || lsu_pend)) begin
                owner_lsu <= lsu_pend; // data wins a tie
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            gnt_req <= lsu_pend ? lsu_req_i : fetch_req_i;
        end
    end

    // bus only carries the request in the transfer cycle
    always_comb begin
        bus_o = '0;
        if (xfer) begin
            bus_o = gnt_req;
        end
    end

    assign fetch_done_o = xfer && !owner_lsu;
    assign lsu_done_o   = xfer && owner_lsu;
    assign rdata_o      = (xfer && gnt_req.read) ? bus_rdata_i : '0;

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst,
    output bus_req_t bus_o,
    input  word_t    bus_rdata_i,
    input  logic     bus_full_i
);

    bus_req_t fetch_req, lsu_req;
    logic     fetch_done, lsu_done;
    word_t    arb_rdata;
    word_t    instr, pc;
    logic     instr_valid;
    decoded_t dec;
    word_t    rs1_data, rs2_data;
    word_t    alu_result, mem_adr;
    logic     branch_taken;
    logic     retire;
    wb_t      wb;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch0 (
        .clk(clk),
        .rst(rst),
        .fetch_req_o(fetch_req),
        .fetch_done_i(fetch_done),
        .rdata_i(arb_rdata),
        .retire_i(retire),
        .branch_taken_i(branch_taken),
        .imm_i(dec.imm),
        .instr_o(instr),
        .pc_o(pc),
        .instr_valid_o(instr_valid)
    );

    instr_decoder dec0 (
        .instr_i(instr),
        .dec_o(dec)
    );

    register_file rf0 (
        .clk(clk),
        .rst(rst),
        .rs1_i(dec.rs1),
        .rs2_i(dec.rs2),
        .wb_i(wb),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    alu alu0 (
        .dec_i(dec),
        .pc_i(pc),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .result_o(alu_result),
        .mem_adr_o(mem_adr),
        .branch_taken_o(branch_taken)
    );

    load_store_unit lsu0 (
        .clk(clk),
        .rst(rst),
        .instr_valid_i(instr_valid),
        .dec_i(dec),
        .mem_adr_i(mem_adr),
        .store_data_i(rs2_data), // sw stores rs2
        .result_i(alu_result),
        .lsu_req_o(lsu_req),
        .lsu_done_i(lsu_done),
        .rdata_i(arb_rdata),
        .retire_o(retire),
        .wb_o(wb)
    );

    bus_arbiter arb0 (
        .clk(clk),
        .rst(rst),
        .fetch_req_i(fetch_req),
        .lsu_req_i(lsu_req),
        .bus_full_i(bus_full_i),
        .bus_rdata_i(bus_rdata_i),
        .bus_o(bus_o),
        .fetch_done_o(fetch_done),
        .lsu_done_o(lsu_done),
        .rdata_o(arb_rdata)
    );

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  reg_idx_t; // register index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // rv32i major opcodes that the core understands
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        OPC_ALU,
        OPC_LOAD,
        OPC_STORE,
        OPC_BRANCH,
        OPC_JAL,
        OPC_LUI,
        OPC_NONE
    } op_class_t;

    typedef struct packed {
        op_class_t op_class;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        funct3_t   funct3;
        logic      sub;     // OP with funct7 0100000
        logic      use_imm; // second operand from imm
        word_t     imm;     // sign-extended
    } decoded_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t adr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQUEST,
        ARB_WAIT,
        ARB_TRANSFER
    } arb_state_t;

    typedef enum logic {
        PH_FETCH,
        PH_EXEC
    } phase_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst,
    output bus_req_t fetch_req_o,
    input  logic     fetch_done_i,
    input  word_t    rdata_i,
    input  logic     retire_i,
    input  logic     branch_taken_i,
    input  word_t    imm_i,
    output word_t    instr_o,
    output word_t    pc_o,
    output logic     instr_valid_o
);

    phase_t phase;
    word_t  pc;
    word_t  ir;      // instruction register
    word_t  next_pc;

    // branch and jal targets are relative to the current pc
    assign next_pc = branch_taken_i ? (pc + imm_i) : (pc + 32'd4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PH_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (phase)
                PH_FETCH: begin
                    if (fetch_done_i) begin
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC: begin
                    if (retire_i) begin
                        pc    <= next_pc;
                        phase <= PH_FETCH;
                    end
                end
                default: phase <= PH_FETCH;
            endcase
        end
    end

    // instruction register loads when the fetch completes
    always_ff @(posedge clk) begin
        if (phase == PH_FETCH && fetch_done_i) begin
            ir <= rdata_i;
        end
    end

    always_comb begin
        fetch_req_o       = '0;
        fetch_req_o.read  = (phase == PH_FETCH); // held until done
        fetch_req_o.adr   = pc;
    end

    assign instr_o       = ir;
    assign pc_o          = pc;
    assign instr_valid_o = (phase == PH_EXEC);

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
    input  word_t    instr_i,
    output decoded_t dec_o
);

    opcode_t opcode;
    word_t   imm_i_fmt, imm_s_fmt, imm_b_fmt, imm_j_fmt, imm_u_fmt;

    assign opcode = instr_i[6:0];

    // sign-extended immediates per format
    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_o          = '0;
        dec_o.rd       = instr_i[11:7];
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.funct3   = instr_i[14:12];
        dec_o.op_class = OPC_NONE; // unknown opcodes retire quietly
        case (opcode)
            OPCODE_OP: begin
                dec_o.op_class = OPC_ALU;
                dec_o.sub      = (instr_i[31:25] == 7'b0100000);
            end
            OPCODE_OP_IMM: begin
                dec_o.op_class = OPC_ALU;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_i_fmt;
            end
            OPCODE_LOAD: begin
                dec_o.op_class = OPC_LOAD;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_i_fmt;
            end
            OPCODE_STORE: begin
                dec_o.op_class = OPC_STORE;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_s_fmt;
            end
            OPCODE_BRANCH: begin
                dec_o.op_class = OPC_BRANCH;
                dec_o.imm      = imm_b_fmt; // compare uses rs2
            end
            OPCODE_JAL: begin
                dec_o.op_class = OPC_JAL;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_j_fmt;
            end
            OPCODE_LUI: begin
                dec_o.op_class = OPC_LUI;
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_u_fmt;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid_i,
    input  decoded_t dec_i,
    input  word_t    mem_adr_i,
    input  word_t    store_data_i,
    input  word_t    result_i,
    output bus_req_t lsu_req_o,
    input  logic     lsu_done_i,
    input  word_t    rdata_i,
    output logic     retire_o,
    output wb_t      wb_o
);

    logic is_load, is_store, is_mem;
    logic busy;   // access open until done
    logic start;  // first exec cycle of a load or store
    logic active;
    logic writes_rd;

    assign is_load  = (dec_i.op_class == OPC_LOAD);
    assign is_store = (dec_i.op_class == OPC_STORE);
    assign is_mem   = is_load || is_store;
    assign start    = instr_valid_i && is_mem && !busy;
    assign active   = start || busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (lsu_done_i) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

    always_comb begin
        lsu_req_o       = '0;
        lsu_req_o.read  = active && is_load;
        lsu_req_o.write = active && is_store;
        lsu_req_o.adr   = mem_adr_i;
        lsu_req_o.wdata = store_data_i;
    end

    // memory ops wait for the bus, everything else finishes at once
    assign retire_o = instr_valid_i && (is_mem ? lsu_done_i : 1'b1);

    assign writes_rd = (dec_i.op_class == OPC_ALU) || (dec_i.op_class == OPC_LOAD) ||
                       (dec_i.op_class == OPC_JAL) || (dec_i.op_class == OPC_LUI);

    assign wb_o.en   = retire_o && writes_rd;
    assign wb_o.rd   = dec_i.rd;
    assign wb_o.data = is_load ? rdata_i : result_i;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  wb_t      wb_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs [0:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wb_i.rd != 5'd0) begin // x0 stays zero
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

// ==== tb.f ====
source/cpu_pkg.sv
source/alu.sv
source/instr_decoder.sv
source/register_file.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/cpu_core.sv
dv/cpu_core_tb.sv
